//--- design/mem_map_pkg.sv
`default_nettype none

package mem_map_pkg;

  // Host bus address width
  localparam int bram_addr_width = 14;

  // Controller page field sits in the top address bits
  localparam int cnt_page_width = 6;

  // Table group selected by the host bus
  typedef enum logic [1:0] {
    sel_controller = 2'd0,
    sel_mod        = 2'd1,
    sel_pwe_table  = 2'd2,
    sel_stm        = 2'd3
  } bram_select_e;

  // Pages inside the controller group
  localparam logic [cnt_page_width-1:0] cnt_page_main       = 6'h00;
  localparam logic [cnt_page_width-1:0] cnt_page_phase_corr = 6'h01;

  // Write-control registers in the main controller page
  localparam logic [bram_addr_width-1:0] addr_mod_wr_segment = 14'h0020;
  localparam logic [bram_addr_width-1:0] addr_mod_wr_page    = 14'h0021;
  localparam logic [bram_addr_width-1:0] addr_stm_wr_segment = 14'h0050;
  localparam logic [bram_addr_width-1:0] addr_stm_wr_page    = 14'h0051;

endpackage

`default_nettype wire

//--- design/array_pkg.sv
`default_nettype none

package array_pkg;

  // Segments per sequenced table
  localparam int num_segment  = 2;
  localparam int segment_width = $clog2(num_segment);

  // Host bus word
  localparam int bus_data_width = 16;

  // Index width of the controller, pulse-width and phase tables
  localparam int table_addr_width = 8;
  // Phase table stores two entries per word
  localparam int phase_word_addr_width = table_addr_width - 1;

  localparam int pwe_value_width   = 9;
  localparam int phase_value_width = 8;

  // Modulation table, one page bit on top of the bus address
  localparam int mod_value_width = 8;
  localparam int mod_page_bits   = 1;
  localparam int mod_idx_width   = 15;

  localparam int stm_value_width = 16;

endpackage

`default_nettype wire

//--- design/dual_port_ram.sv
`timescale 1ns/1ps
`default_nettype none

module dual_port_ram #(
  parameter int data_width = 16,
  parameter int addr_width = 8
) (
  // Port A
  input  logic                  clk_a,
  input  logic                  en_a,
  input  logic                  we_a,
  input  logic [addr_width-1:0] addr_a,
  input  logic [data_width-1:0] din_a,
  output logic [data_width-1:0] dout_a,
  // Port B, always enabled
  input  logic                  clk_b,
  input  logic                  we_b,
  input  logic [addr_width-1:0] addr_b,
  input  logic [data_width-1:0] din_b,
  output logic [data_width-1:0] dout_b
);

  logic [data_width-1:0] mem [2**addr_width];

  // Port A keeps its output during writes, so a read result holds
  always @(posedge clk_a) begin
    if (en_a) begin
      if (we_a) begin
        mem[addr_a] <= din_a;
      end else begin
        dout_a <= mem[addr_a];
      end
    end
  end

  // Port B reads every cycle, old data on a same-address write
  always @(posedge clk_b) begin
    if (we_b) begin
      mem[addr_b] <= din_b;
    end
    dout_b <= mem[addr_b];
  end

endmodule

`default_nettype wire

//--- design/bram_bus_decode.sv
`timescale 1ns/1ps
`default_nettype none

module bram_bus_decode
  import mem_map_pkg::*;
  import array_pkg::*;
(
  input  logic                       bus_clk,
  input  logic                       arst_n,
  input  logic                       en,
  input  logic                       we,
  input  bram_select_e               bram_select,
  input  logic [bram_addr_width-1:0] bram_addr,
  input  logic [bus_data_width-1:0]  ctl_dout,
  output logic [bus_data_width-1:0]  data_out,
  output logic                       ctl_en,
  output logic                       phase_corr_en,
  output logic                       pwe_en,
  output logic                       mod_en,
  output logic                       stm_en
);

  logic [cnt_page_width-1:0] cnt_page;
  logic                      rd_ctl_q;

  assign cnt_page = bram_addr[bram_addr_width-1 -: cnt_page_width];

  // Controller group is split further by page
  assign ctl_en        = en && (bram_select == sel_controller) && (cnt_page == cnt_page_main);
  assign phase_corr_en = en && (bram_select == sel_controller)
                         && (cnt_page == cnt_page_phase_corr);
  assign pwe_en        = en && (bram_select == sel_pwe_table);
  assign mod_en        = en && (bram_select == sel_mod);
  assign stm_en        = en && (bram_select == sel_stm);

  // Remember the target of the last read
  always_ff @(posedge bus_clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_ctl_q <= 1'b0;
    end else if (en && !we) begin
      rd_ctl_q <= ctl_en;
    end
  end

  // Only the register file is readable from the host
  assign data_out = rd_ctl_q ? ctl_dout : '0;

  // Host read data holds until the next read
  a_data_out_holds: assert property (@(posedge bus_clk) disable iff (!arst_n)
    !(en && !we) |=> $stable(data_out))
    else $error("bram_bus_decode: data_out changed without a host read");

endmodule

`default_nettype wire

//--- design/segment_page_regs.sv
`timescale 1ns/1ps
`default_nettype none

module segment_page_regs
  import mem_map_pkg::*;
  import array_pkg::*;
#(
  parameter int stm_page_bits = 4
) (
  input  logic                       bus_clk,
  input  logic                       arst_n,
  input  logic                       ctl_en,
  input  logic                       we,
  input  logic [bram_addr_width-1:0] bram_addr,
  input  logic [bus_data_width-1:0]  data_in,
  output logic [segment_width-1:0]   mod_wr_segment,
  output logic [mod_page_bits-1:0]   mod_wr_page,
  output logic [segment_width-1:0]   stm_wr_segment,
  output logic [stm_page_bits-1:0]   stm_wr_page
);

  logic [2:0]                 wr_hist;
  logic [bram_addr_width-1:0] addr_q;
  logic [bus_data_width-1:0]  data_q;
  logic                       held_write;

  // Newest sample in bit 0
  always_ff @(posedge bus_clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_hist <= '0;
    end else begin
      wr_hist <= {wr_hist[1:0], ctl_en & we};
    end
  end

  // Address and data of the newest sample
  always_ff @(posedge bus_clk) begin
    addr_q <= bram_addr;
    data_q <= data_in;
  end

  // Two strobed samples after an idle one
  assign held_write = (wr_hist == 3'b011);

  always_ff @(posedge bus_clk or negedge arst_n) begin
    if (!arst_n) begin
      mod_wr_segment <= '0;
      mod_wr_page    <= '0;
      stm_wr_segment <= '0;
      stm_wr_page    <= '0;
    end else if (held_write) begin
      case (addr_q)
        addr_mod_wr_segment: mod_wr_segment <= data_q[segment_width-1:0];
        addr_mod_wr_page:    mod_wr_page    <= data_q[mod_page_bits-1:0];
        addr_stm_wr_segment: stm_wr_segment <= data_q[segment_width-1:0];
        addr_stm_wr_page:    stm_wr_page    <= data_q[stm_page_bits-1:0];
        default: begin
        end
      endcase
    end
  end

  // A change needs a controller write to that table's registers two samples back
  a_mod_regs_source: assert property (@(posedge bus_clk) disable iff (!arst_n)
    $changed({mod_wr_segment, mod_wr_page}) |-> $past(ctl_en && we
      && (bram_addr == addr_mod_wr_segment || bram_addr == addr_mod_wr_page), 2))
    else $error("segment_page_regs: modulation register changed without a write");

  a_stm_regs_source: assert property (@(posedge bus_clk) disable iff (!arst_n)
    $changed({stm_wr_segment, stm_wr_page}) |-> $past(ctl_en && we
      && (bram_addr == addr_stm_wr_segment || bram_addr == addr_stm_wr_page), 2))
    else $error("segment_page_regs: STM register changed without a write");

endmodule

`default_nettype wire

//--- design/segment_bank.sv
`timescale 1ns/1ps
`default_nettype none

module segment_bank
  import mem_map_pkg::*;
  import array_pkg::*;
#(
  parameter int data_width      = 8,
  parameter int page_bits       = 1,
  parameter int read_addr_width = 15
) (
  input  logic                       bus_clk,
  input  logic                       en,
  input  logic                       we,
  input  logic [segment_width-1:0]   wr_segment,
  input  logic [page_bits-1:0]       wr_page,
  input  logic [bram_addr_width-1:0] bram_addr,
  input  logic [bus_data_width-1:0]  data_in,
  input  logic [segment_width-1:0]   rd_segment,
  input  logic [read_addr_width-1:0] rd_idx,
  output logic [data_width-1:0]      rd_value
);

  localparam int wr_addr_width = page_bits + bram_addr_width;

  logic [wr_addr_width-1:0] wr_addr;
  logic [data_width-1:0]    seg_value [num_segment];
  logic [segment_width-1:0] rd_segment_q;

  // Both ports share one RAM address width
  if (read_addr_width != wr_addr_width) begin : g_width_check
    $error("segment_bank: read_addr_width must be page_bits + bram_addr_width");
  end

  // Page bits extend the bus address
  assign wr_addr = {wr_page, bram_addr};

  for (genvar s = 0; s < num_segment; s++) begin : g_seg
    dual_port_ram #(
      .data_width(data_width),
      .addr_width(read_addr_width)
    ) ram_i (
      .clk_a  (bus_clk),
      .en_a   (en && (wr_segment == segment_width'(s))),
      .we_a   (we),
      .addr_a (wr_addr),
      .din_a  (data_in[data_width-1:0]),
      .dout_a (),
      .clk_b  (bus_clk),
      .we_b   (1'b0),
      .addr_b (rd_idx),
      .din_b  ('0),
      .dout_b (seg_value[s])
    );
  end

  // Segment follows the read it belongs to
  always_ff @(posedge bus_clk) begin
    rd_segment_q <= rd_segment;
  end

  assign rd_value = seg_value[rd_segment_q];

  a_rd_segment_known: assert property (@(posedge bus_clk)
    !$isunknown(rd_idx) |-> !$isunknown(rd_segment))
    else $error("segment_bank: read segment unknown during a read");

endmodule

`default_nettype wire

//--- design/phase_corr_table.sv
`timescale 1ns/1ps
`default_nettype none

module phase_corr_table
  import array_pkg::*;
(
  input  logic                             bus_clk,
  input  logic                             en,
  input  logic                             we,
  input  logic [phase_word_addr_width-1:0] bram_addr,
  input  logic [bus_data_width-1:0]        data_in,
  input  logic [table_addr_width-1:0]      idx,
  output logic [phase_value_width-1:0]     value
);

  logic [bus_data_width-1:0] word;
  logic                      odd_q;

  // Two phase entries per bus word
  dual_port_ram #(
    .data_width(bus_data_width),
    .addr_width(phase_word_addr_width)
  ) ram_i (
    .clk_a  (bus_clk),
    .en_a   (en),
    .we_a   (we),
    .addr_a (bram_addr),
    .din_a  (data_in),
    .dout_a (),
    .clk_b  (bus_clk),
    .we_b   (1'b0),
    .addr_b (idx[table_addr_width-1:1]),
    .din_b  ('0),
    .dout_b (word)
  );

  always_ff @(posedge bus_clk) begin
    odd_q <= idx[0];
  end

  // Odd index takes the high byte
  assign value = odd_q ? word[bus_data_width-1 -: phase_value_width]
                       : word[phase_value_width-1:0];

endmodule

`default_nettype wire

//--- design/memory.sv
`timescale 1ns/1ps
`default_nettype none

module memory
  import mem_map_pkg::*;
  import array_pkg::*;
#(
  parameter int stm_page_bits = 4
) (
  input  logic                                     bus_clk,
  input  logic                                     arst_n,
  // Host bus
  input  logic                                     en,
  input  logic                                     we,
  input  bram_select_e                             bram_select,
  input  logic [bram_addr_width-1:0]               bram_addr,
  input  logic [bus_data_width-1:0]                data_in,
  output logic [bus_data_width-1:0]                data_out,
  // Drive engine, controller register file
  input  logic                                     cnt_we,
  input  logic [table_addr_width-1:0]              cnt_addr,
  input  logic [bus_data_width-1:0]                cnt_din,
  output logic [bus_data_width-1:0]                cnt_dout,
  // Drive engine, table reads
  input  logic [table_addr_width-1:0]              phase_corr_idx,
  output logic [phase_value_width-1:0]             phase_corr_value,
  input  logic [table_addr_width-1:0]              pwe_idx,
  output logic [pwe_value_width-1:0]               pwe_value,
  input  logic [segment_width-1:0]                 mod_segment,
  input  logic [mod_idx_width-1:0]                 mod_idx,
  output logic [mod_value_width-1:0]               mod_value,
  input  logic [segment_width-1:0]                 stm_segment,
  input  logic [stm_page_bits+bram_addr_width-1:0] stm_idx,
  output logic [stm_value_width-1:0]               stm_value
);

  logic                      ctl_en;
  logic                      phase_corr_en;
  logic                      pwe_en;
  logic                      mod_en;
  logic                      stm_en;
  logic [bus_data_width-1:0] ctl_dout;
  logic [bus_data_width-1:0] pwe_dout;
  logic [segment_width-1:0]  mod_wr_segment;
  logic [mod_page_bits-1:0]  mod_wr_page;
  logic [segment_width-1:0]  stm_wr_segment;
  logic [stm_page_bits-1:0]  stm_wr_page;

  bram_bus_decode decode_i (
    .bus_clk       (bus_clk),
    .arst_n        (arst_n),
    .en            (en),
    .we            (we),
    .bram_select   (bram_select),
    .bram_addr     (bram_addr),
    .ctl_dout      (ctl_dout),
    .data_out      (data_out),
    .ctl_en        (ctl_en),
    .phase_corr_en (phase_corr_en),
    .pwe_en        (pwe_en),
    .mod_en        (mod_en),
    .stm_en        (stm_en)
  );

  segment_page_regs #(
    .stm_page_bits(stm_page_bits)
  ) page_regs_i (
    .bus_clk        (bus_clk),
    .arst_n         (arst_n),
    .ctl_en         (ctl_en),
    .we             (we),
    .bram_addr      (bram_addr),
    .data_in        (data_in),
    .mod_wr_segment (mod_wr_segment),
    .mod_wr_page    (mod_wr_page),
    .stm_wr_segment (stm_wr_segment),
    .stm_wr_page    (stm_wr_page)
  );

  // Register file, host on port A and drive engine on port B
  dual_port_ram #(
    .data_width(bus_data_width),
    .addr_width(table_addr_width)
  ) ctl_ram_i (
    .clk_a  (bus_clk),
    .en_a   (ctl_en),
    .we_a   (we),
    .addr_a (bram_addr[table_addr_width-1:0]),
    .din_a  (data_in),
    .dout_a (ctl_dout),
    .clk_b  (bus_clk),
    .we_b   (cnt_we),
    .addr_b (cnt_addr),
    .din_b  (cnt_din),
    .dout_b (cnt_dout)
  );

  phase_corr_table phase_corr_i (
    .bus_clk   (bus_clk),
    .en        (phase_corr_en),
    .we        (we),
    .bram_addr (bram_addr[phase_word_addr_width-1:0]),
    .data_in   (data_in),
    .idx       (phase_corr_idx),
    .value     (phase_corr_value)
  );

  dual_port_ram #(
    .data_width(bus_data_width),
    .addr_width(table_addr_width)
  ) pwe_ram_i (
    .clk_a  (bus_clk),
    .en_a   (pwe_en),
    .we_a   (we),
    .addr_a (bram_addr[table_addr_width-1:0]),
    .din_a  (data_in),
    .dout_a (),
    .clk_b  (bus_clk),
    .we_b   (1'b0),
    .addr_b (pwe_idx),
    .din_b  ('0),
    .dout_b (pwe_dout)
  );

  assign pwe_value = pwe_dout[pwe_value_width-1:0];

  segment_bank #(
    .data_width      (mod_value_width),
    .page_bits       (mod_page_bits),
    .read_addr_width (mod_idx_width)
  ) mod_bank_i (
    .bus_clk    (bus_clk),
    .en         (mod_en),
    .we         (we),
    .wr_segment (mod_wr_segment),
    .wr_page    (mod_wr_page),
    .bram_addr  (bram_addr),
    .data_in    (data_in),
    .rd_segment (mod_segment),
    .rd_idx     (mod_idx),
    .rd_value   (mod_value)
  );

  segment_bank #(
    .data_width      (stm_value_width),
    .page_bits       (stm_page_bits),
    .read_addr_width (stm_page_bits + bram_addr_width)
  ) stm_bank_i (
    .bus_clk    (bus_clk),
    .en         (stm_en),
    .we         (we),
    .wr_segment (stm_wr_segment),
    .wr_page    (stm_wr_page),
    .bram_addr  (bram_addr),
    .data_in    (data_in),
    .rd_segment (stm_segment),
    .rd_idx     (stm_idx),
    .rd_value   (stm_value)
  );

endmodule

`default_nettype wire

//--- bench/memory_tb.sv
`timescale 1ns/1ps
`default_nettype none

module memory_tb
  import mem_map_pkg::*;
();

  localparam int clk_period    = 100;
  localparam int stm_page_bits = 2;
  localparam int max_ops       = 64;
  localparam int op_words      = 6;
  localparam logic [31:0] lfsr_taps = 32'hd000_0001;

  typedef enum logic [3:0] {
    op_test        = 4'h0,
    op_write       = 4'h1,
    op_hold_write  = 4'h2,
    op_read        = 4'h3,
    op_drive_read  = 4'h4,
    op_drive_write = 4'h5,
    op_random      = 4'h6,
    op_end         = 4'hf
  } op_e;

  typedef enum logic [2:0] {
    port_cnt   = 3'd0,
    port_phase = 3'd1,
    port_pwe   = 3'd2,
    port_mod   = 3'd3,
    port_stm   = 3'd4,
    port_host  = 3'd5
  } port_e;

  logic         bus_clk;
  logic         arst_n;
  logic         en;
  logic         we;
  bram_select_e bram_select;
  logic [13:0]  bram_addr;
  logic [15:0]  data_in;
  logic [15:0]  data_out;
  logic         cnt_we;
  logic [7:0]   cnt_addr;
  logic [15:0]  cnt_din;
  logic [15:0]  cnt_dout;
  logic [7:0]   phase_corr_idx;
  logic [7:0]   phase_corr_value;
  logic [7:0]   pwe_idx;
  logic [8:0]   pwe_value;
  logic         mod_segment;
  logic [14:0]  mod_idx;
  logic [7:0]   mod_value;
  logic         stm_segment;
  logic [15:0]  stm_idx;
  logic [15:0]  stm_value;

  logic [31:0] stim [0:max_ops*op_words-1];
  int          num_ops;
  bit          ops_ready;
  logic [31:0] lfsr_state;

  // Reference model of every table indexed by read address
  logic [15:0] ctl_model [int];
  logic [7:0]  phase_model [int];
  logic [8:0]  pwe_model [int];
  logic [7:0]  mod_model [int];
  logic [15:0] stm_model [int];
  logic        mod_seg_m;
  logic        mod_page_m;
  logic        stm_seg_m;
  logic [1:0]  stm_page_m;

  int errors;
  int checks;
  int test_errors;
  int test_checks;
  int tests_run;
  int tests_failed;
  int cur_test;

  memory #(
    .stm_page_bits(stm_page_bits)
  ) dut_i (
    .bus_clk          (bus_clk),
    .arst_n           (arst_n),
    .en               (en),
    .we               (we),
    .bram_select      (bram_select),
    .bram_addr        (bram_addr),
    .data_in          (data_in),
    .data_out         (data_out),
    .cnt_we           (cnt_we),
    .cnt_addr         (cnt_addr),
    .cnt_din          (cnt_din),
    .cnt_dout         (cnt_dout),
    .phase_corr_idx   (phase_corr_idx),
    .phase_corr_value (phase_corr_value),
    .pwe_idx          (pwe_idx),
    .pwe_value        (pwe_value),
    .mod_segment      (mod_segment),
    .mod_idx          (mod_idx),
    .mod_value        (mod_value),
    .stm_segment      (stm_segment),
    .stm_idx          (stm_idx),
    .stm_value        (stm_value)
  );

  initial begin
    bus_clk = 1'b0;
    forever #(clk_period / 2) bus_clk = ~bus_clk;
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ lfsr_taps) : (s >> 1);
  endfunction

  // One LFSR step per returned bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int b = 0; b < n; b++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic string signal_name(input port_e port);
    case (port)
      port_cnt:   return "cnt_dout";
      port_phase: return "phase_corr_value";
      port_pwe:   return "pwe_value";
      port_mod:   return "mod_value";
      port_stm:   return "stm_value";
      default:    return "data_out";
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    test_checks++;
    if (got !== exp) begin
      errors++;
      test_errors++;
      $display("ERR t=%0t %s: got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic finish_test();
    if (cur_test != 0) begin
      tests_run++;
      if (test_errors != 0) begin
        tests_failed++;
      end
      $display("test %0d: %s, %0d checks, %0d errors", cur_test,
               (test_errors == 0) ? "ok" : "failed", test_checks, test_errors);
    end
    test_checks = 0;
    test_errors = 0;
  endtask

  // Address rules of the block as seen by the model
  task automatic model_write(input bram_select_e sel, input logic [13:0] addr,
                             input logic [15:0] data, input bit held);
    case (sel)
      sel_controller: begin
        if (addr[13:8] == cnt_page_main) begin
          ctl_model[addr[7:0]] = data;
          if (held && addr == addr_mod_wr_segment) mod_seg_m = data[0];
          if (held && addr == addr_mod_wr_page) mod_page_m = data[0];
          if (held && addr == addr_stm_wr_segment) stm_seg_m = data[0];
          if (held && addr == addr_stm_wr_page) stm_page_m = data[1:0];
        end else if (addr[13:8] == cnt_page_phase_corr) begin
          phase_model[{addr[6:0], 1'b0}] = data[7:0];
          phase_model[{addr[6:0], 1'b1}] = data[15:8];
        end
      end
      sel_mod:       mod_model[{mod_seg_m, mod_page_m, addr}] = data[7:0];
      sel_pwe_table: pwe_model[addr[7:0]] = data[8:0];
      default:       stm_model[{stm_seg_m, stm_page_m, addr}] = data;
    endcase
  endtask

  function automatic bit model_lookup(input port_e port, input logic [15:0] idx,
                                      input logic seg, output logic [15:0] exp);
    exp = '0;
    case (port)
      port_cnt, port_host: begin
        if (!ctl_model.exists(idx[7:0])) return 0;
        exp = ctl_model[idx[7:0]];
      end
      port_phase: begin
        if (!phase_model.exists(idx[7:0])) return 0;
        exp = phase_model[idx[7:0]];
      end
      port_pwe: begin
        if (!pwe_model.exists(idx[7:0])) return 0;
        exp = pwe_model[idx[7:0]];
      end
      port_mod: begin
        if (!mod_model.exists({seg, idx[14:0]})) return 0;
        exp = mod_model[{seg, idx[14:0]}];
      end
      default: begin
        if (!stm_model.exists({seg, idx})) return 0;
        exp = stm_model[{seg, idx}];
      end
    endcase
    return 1;
  endfunction

  // Strobe held for the given number of cycles and then an idle cycle
  task automatic host_write(input bram_select_e sel, input logic [13:0] addr,
                            input logic [15:0] data, input int cycles);
    @(posedge bus_clk);
    #1;
    en          = 1'b1;
    we          = 1'b1;
    bram_select = sel;
    bram_addr   = addr;
    data_in     = data;
    repeat (cycles - 1) @(posedge bus_clk);
    @(posedge bus_clk);
    #1;
    en = 1'b0;
    we = 1'b0;
  endtask

  task automatic host_read(input bram_select_e sel, input logic [13:0] addr,
                           output logic [15:0] value);
    @(posedge bus_clk);
    #1;
    en          = 1'b1;
    we          = 1'b0;
    bram_select = sel;
    bram_addr   = addr;
    @(posedge bus_clk);
    #1;
    en = 1'b0;
    @(negedge bus_clk);
    value = data_out;
  endtask

  task automatic drive_write(input logic [7:0] addr, input logic [15:0] data);
    @(posedge bus_clk);
    #1;
    cnt_we   = 1'b1;
    cnt_addr = addr;
    cnt_din  = data;
    @(posedge bus_clk);
    #1;
    cnt_we = 1'b0;
  endtask

  task automatic drive_read(input port_e port, input logic [15:0] idx, input logic seg,
                            output logic [15:0] value);
    @(posedge bus_clk);
    #1;
    case (port)
      port_cnt:   cnt_addr = idx[7:0];
      port_phase: phase_corr_idx = idx[7:0];
      port_pwe:   pwe_idx = idx[7:0];
      port_mod: begin
        mod_idx     = idx[14:0];
        mod_segment = seg;
      end
      default: begin
        stm_idx     = idx;
        stm_segment = seg;
      end
    endcase
    // One cycle of read latency
    @(posedge bus_clk);
    @(negedge bus_clk);
    case (port)
      port_cnt:   value = cnt_dout;
      port_phase: value = {8'h00, phase_corr_value};
      port_pwe:   value = {7'h00, pwe_value};
      port_mod:   value = {8'h00, mod_value};
      default:    value = stm_value;
    endcase
  endtask

  // Reads back only entries the model knows
  task automatic check_entry(input port_e port, input logic [15:0] idx, input logic seg);
    logic [15:0] exp;
    logic [15:0] got;
    if (model_lookup(port, idx, seg, exp)) begin
      if (port == port_host) begin
        host_read(sel_controller, {cnt_page_main, idx[7:0]}, got);
      end else begin
        drive_read(port, idx, seg, got);
      end
      check_value(signal_name(port), got, exp);
    end
  endtask

  task automatic random_test(input int count);
    int           tbl;
    logic [13:0]  addr;
    logic [15:0]  data;
    bram_select_e sel;
    int           rec_tbl [$];
    logic [13:0]  rec_addr [$];
    logic [15:0]  rec_idx [$];
    logic         rec_seg [$];
    for (int n = 0; n < count; n++) begin
      tbl  = rand_bits(3) % 5;
      addr = rand_bits(14);
      data = rand_bits(16);
      // Few low address bits so the small tables share indices
      addr[7:3] = '0;
      case (tbl)
        0: begin
          sel        = sel_controller;
          addr[13:8] = cnt_page_main;
        end
        1: begin
          sel        = sel_controller;
          addr[13:7] = {cnt_page_phase_corr, 1'b0};
        end
        2:       sel = sel_pwe_table;
        3:       sel = sel_mod;
        default: sel = sel_stm;
      endcase
      rec_tbl.push_back(tbl);
      rec_addr.push_back(addr);
      rec_idx.push_back((tbl == 3) ? {1'b0, mod_page_m, addr} : {stm_page_m, addr});
      rec_seg.push_back((tbl == 3) ? mod_seg_m : stm_seg_m);
      model_write(sel, addr, data, 1'b0);
      host_write(sel, addr, data, 1);
    end
    // Small tables at each index catch writes through the wrong select
    foreach (rec_tbl[k]) begin
      check_entry(port_host, {8'h00, rec_addr[k][7:0]}, 1'b0);
      check_entry(port_pwe, {8'h00, rec_addr[k][7:0]}, 1'b0);
      check_entry(port_phase, {8'h00, rec_addr[k][7:0]}, 1'b0);
      case (rec_tbl[k])
        1: begin
          check_entry(port_phase, {8'h00, rec_addr[k][6:0], 1'b0}, 1'b0);
          check_entry(port_phase, {8'h00, rec_addr[k][6:0], 1'b1}, 1'b0);
        end
        3:       check_entry(port_mod, rec_idx[k], rec_seg[k]);
        4:       check_entry(port_stm, rec_idx[k], rec_seg[k]);
        default: ;
      endcase
    end
  endtask

  task automatic run_op(input int k);
    op_e         op;
    logic [31:0] sel_f;
    logic [31:0] addr_f;
    logic [31:0] data_f;
    logic [31:0] seg_f;
    logic [31:0] exp_f;
    logic [15:0] got;
    op     = op_e'(stim[k*op_words][3:0]);
    sel_f  = stim[k*op_words+1];
    addr_f = stim[k*op_words+2];
    data_f = stim[k*op_words+3];
    seg_f  = stim[k*op_words+4];
    exp_f  = stim[k*op_words+5];
    case (op)
      op_test: begin
        finish_test();
        cur_test = sel_f;
      end
      op_write, op_hold_write: begin
        model_write(bram_select_e'(sel_f[1:0]), addr_f[13:0], data_f[15:0],
                    op == op_hold_write);
        host_write(bram_select_e'(sel_f[1:0]), addr_f[13:0], data_f[15:0],
                   (op == op_hold_write) ? 2 : 1);
      end
      op_read: begin
        host_read(bram_select_e'(sel_f[1:0]), addr_f[13:0], got);
        check_value("data_out", got, exp_f);
      end
      op_drive_read: begin
        drive_read(port_e'(sel_f[2:0]), addr_f[15:0], seg_f[0], got);
        check_value(signal_name(port_e'(sel_f[2:0])), got, exp_f);
      end
      op_drive_write: begin
        ctl_model[addr_f[7:0]] = data_f[15:0];
        drive_write(addr_f[7:0], data_f[15:0]);
      end
      op_random: random_test(data_f);
      default: begin
        errors++;
        $display("unknown opcode %h in operation %0d of the stimulus file", op, k + 1);
      end
    endcase
  endtask

  initial begin
    arst_n         = 1'b0;
    en             = 1'b0;
    we             = 1'b0;
    bram_select    = sel_controller;
    bram_addr      = '0;
    data_in        = '0;
    cnt_we         = 1'b0;
    cnt_addr       = '0;
    cnt_din        = '0;
    phase_corr_idx = '0;
    pwe_idx        = '0;
    mod_segment    = 1'b0;
    mod_idx        = '0;
    stm_segment    = 1'b0;
    stm_idx        = '0;
    mod_seg_m      = 1'b0;
    mod_page_m     = 1'b0;
    stm_seg_m      = 1'b0;
    stm_page_m     = '0;
    lfsr_state     = 32'h6f08_18b2;
    $readmemh("bench/memory_input.txt", stim);
    repeat (10) @(posedge bus_clk);
    #1;
    arst_n = 1'b1;
    if ($isunknown(stim[0])) begin
      errors++;
      $display("could not read the stimulus file bench/memory_input.txt");
    end else begin
      while (num_ops < max_ops && !$isunknown(stim[num_ops*op_words])
             && stim[num_ops*op_words][3:0] != op_end) begin
        num_ops++;
      end
      ops_ready = 1'b1;
      check_value("data_out", data_out, 32'h0);
      for (int k = 0; k < num_ops; k++) begin
        run_op(k);
      end
      finish_test();
    end
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // Budget grows with the number of operations
  initial begin
    wait (ops_ready);
    repeat (num_ops * 10 + 200) @(posedge bus_clk);
    $display("timeout after %0d cycles, the operations did not complete",
             num_ops * 10 + 200);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- memory.f
design/mem_map_pkg.sv
design/array_pkg.sv
design/dual_port_ram.sv
design/bram_bus_decode.sv
design/segment_page_regs.sv
design/segment_bank.sv
design/phase_corr_table.sv
design/memory.sv
bench/memory_tb.sv

//--- Bender.yml
package:
  name: memory

sources:
  - files:
      - design/mem_map_pkg.sv
      - design/array_pkg.sv
      - design/dual_port_ram.sv
      - design/bram_bus_decode.sv
      - design/segment_page_regs.sv
      - design/segment_bank.sv
      - design/phase_corr_table.sv
      - design/memory.sv
  - target: test
    files:
      - bench/memory_tb.sv

//--- bench/memory_input.txt
// Columns: opcode, select or port or test number, address or index, data or count, segment, expected
// Opcodes: 0 test start, 1 write, 2 held write, 3 host read, 4 drive read, 5 drive write, 6 random, f end
0 1 0000 0000 0 0000
1 0 0005 1234 0 0000
1 0 0006 abcd 0 0000
3 0 0005 0000 0 1234
3 0 0006 0000 0 abcd
5 0 0007 5a5a 0 0000
3 0 0007 0000 0 5a5a
4 0 0005 0000 0 1234
3 2 0005 0000 0 0000
0 2 0000 0000 0 0000
1 0 0103 b7a4 0 0000
4 1 0006 0000 0 00a4
4 1 0007 0000 0 00b7
1 2 0010 7f5c 0 0000
4 2 0010 0000 0 015c
0 3 0000 0000 0 0000
1 1 0040 0011 0 0000
1 3 0040 2222 0 0000
2 0 0020 0001 0 0000
2 0 0050 0001 0 0000
2 0 0051 0002 0 0000
1 1 0040 0099 0 0000
1 3 0040 7777 0 0000
4 3 0040 0000 1 0099
4 3 0040 0000 0 0011
4 4 8040 0000 1 7777
4 4 0040 0000 0 2222
0 4 0000 0000 0 0000
1 0 0020 0000 0 0000
1 1 0041 003c 0 0000
4 3 0041 0000 1 003c
3 0 0020 0000 0 0000
0 5 0000 0000 0 0000
6 0 0000 000c 0 0000
f 0 0000 0000 0 0000
